//--- dcache.sv
module dcache (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       dc_pre_valid,
    input  logic [lsu_pkg::ADDR_W-1:0] dc_vaddr,
    input  logic                       dc_valid,
    input  logic [lsu_pkg::ADDR_W-1:0] dc_addr,
    input  logic [lsu_pkg::DATA_W-1:0] dc_wdata,
    input  logic [lsu_pkg::NBYTES-1:0] dc_wstrb,
    output logic                       dc_ready,
    output logic [lsu_pkg::DATA_W-1:0] dc_rdata,

    output logic                       mem_req,
    output logic                       mem_we,
    output logic [lsu_pkg::ADDR_W-1:0] mem_addr,
    output logic [lsu_pkg::DATA_W-1:0] mem_wdata,
    output logic [lsu_pkg::NBYTES-1:0] mem_wstrb,
    input  logic                       mem_ack,
    input  logic [lsu_pkg::DATA_W-1:0] mem_rdata
);
    import lsu_pkg::*;

    logic [TAG_W-1:0]    tag_arr  [2**IDX_W];
    logic [DATA_W-1:0]   data_arr [2**IDX_W];
    logic [2**IDX_W-1:0] vld_arr;

    dc_state_e state;

    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic [NBYTES-1:0] req_wstrb;

    // Line read ahead on dc_pre_valid
    logic [IDX_W-1:0]  rd_idx;
    logic [TAG_W-1:0]  rd_tag;
    logic              rd_vld;
    logic [DATA_W-1:0] rd_data;

    // Same line frozen for the lookup cycle
    logic [IDX_W-1:0]  lk_idx;
    logic [TAG_W-1:0]  lk_tag;
    logic              lk_vld;
    logic [DATA_W-1:0] lk_data;

    logic [IDX_W-1:0]  pre_idx;
    logic [IDX_W-1:0]  req_idx;
    logic [TAG_W-1:0]  req_tag;
    logic              req_store;
    logic              hit;
    logic              accept;
    logic              wr_en;
    logic [DATA_W-1:0] wr_data;
    logic [DATA_W-1:0] merged;

    assign pre_idx   = dc_vaddr[IDX_W+1:2];
    assign req_idx   = req_addr[IDX_W+1:2];
    assign req_tag   = req_addr[ADDR_W-1:IDX_W+2];
    assign req_store = |req_wstrb;
    assign hit       = lk_vld && (lk_idx == req_idx) && (lk_tag == req_tag);

    assign dc_ready = (state == DC_LOOKUP && hit && !req_store)
                      || (state == DC_MEM && mem_ack);
    assign dc_rdata = (state == DC_MEM) ? mem_rdata : lk_data;
    assign accept   = dc_valid && (state == DC_IDLE || (state == DC_LOOKUP && dc_ready));

    always_comb begin
        merged = lk_data;
        for (int b = 0; b < NBYTES; b++) begin
            if (req_wstrb[b]) begin
                merged[b*8 +: 8] = req_wdata[b*8 +: 8];
            end
        end
    end

    // Store hit updates the line and a load refill fills it
    assign wr_en   = (state == DC_LOOKUP && hit && req_store)
                     || (state == DC_MEM && mem_ack && !req_store);
    assign wr_data = (state == DC_MEM) ? mem_rdata : merged;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= DC_IDLE;
        end else begin
            case (state)
                DC_IDLE: begin
                    if (dc_valid) begin
                        state <= DC_LOOKUP;
                    end
                end
                DC_LOOKUP: begin
                    if (!hit || req_store) begin
                        state <= DC_MEM;
                    end else if (!dc_valid) begin
                        state <= DC_IDLE;
                    end
                end
                DC_MEM: begin
                    if (mem_ack) begin
                        state <= DC_IDLE;
                    end
                end
                default: state <= DC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_arr <= '0;
            rd_vld  <= 1'b0;
        end else begin
            if (wr_en) begin
                vld_arr[req_idx] <= 1'b1;
            end
            if (dc_pre_valid) begin
                rd_vld <= vld_arr[pre_idx] || (wr_en && req_idx == pre_idx);
            end else if (wr_en && req_idx == rd_idx) begin
                rd_vld <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_arr[req_idx]  <= req_tag;
            data_arr[req_idx] <= wr_data;
        end
        if (dc_pre_valid) begin
            rd_idx <= pre_idx;
            if (wr_en && req_idx == pre_idx) begin
                rd_tag  <= req_tag;
                rd_data <= wr_data;
            end else begin
                rd_tag  <= tag_arr[pre_idx];
                rd_data <= data_arr[pre_idx];
            end
        end else if (wr_en && req_idx == rd_idx) begin
            rd_tag  <= req_tag;
            rd_data <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= dc_addr;
            req_wdata <= dc_wdata;
            req_wstrb <= dc_wstrb;
            lk_idx    <= rd_idx;
            lk_tag    <= rd_tag;
            lk_vld    <= rd_vld;
            lk_data   <= rd_data;
        end
    end

    // Write through carries the store strobes and a refill reads a whole word
    assign mem_req   = state == DC_MEM;
    assign mem_we    = req_store;
    assign mem_addr  = {req_addr[ADDR_W-1:2], 2'b00};
    assign mem_wdata = req_wdata;
    assign mem_wstrb = req_wstrb;

endmodule

//--- lsu.sv
module lsu (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       cpu_pre_valid,
    input  logic [lsu_pkg::ADDR_W-1:0] cpu_vaddr,
    input  logic                       cpu_valid,
    input  logic                       cpu_uncached,
    input  lsu_pkg::req_size_e         cpu_size,
    input  logic [lsu_pkg::ADDR_W-1:0] cpu_addr,
    input  logic [lsu_pkg::DATA_W-1:0] cpu_wdata,
    input  logic [lsu_pkg::NBYTES-1:0] cpu_wstrb,
    input  logic                       cpu_flush,
    output logic                       cpu_ready,
    output logic [lsu_pkg::DATA_W-1:0] cpu_rdata,
    output logic                       cpu_data_valid,

    output logic                       dc_pre_valid,
    output logic [lsu_pkg::ADDR_W-1:0] dc_vaddr,
    output logic                       dc_valid,
    output logic [lsu_pkg::ADDR_W-1:0] dc_addr,
    output logic [lsu_pkg::DATA_W-1:0] dc_wdata,
    output logic [lsu_pkg::NBYTES-1:0] dc_wstrb,
    input  logic [lsu_pkg::DATA_W-1:0] dc_rdata,
    input  logic                       dc_ready,

    output logic                       unc_valid,
    output lsu_pkg::req_size_e         unc_size,
    output logic [lsu_pkg::ADDR_W-1:0] unc_addr,
    output logic [lsu_pkg::DATA_W-1:0] unc_wdata,
    output logic [lsu_pkg::NBYTES-1:0] unc_wstrb,
    input  logic                       unc_ready,
    input  logic [lsu_pkg::DATA_W-1:0] unc_rdata,
    input  logic                       unc_data_ok
);
    import lsu_pkg::*;

    lsu_state_e state;
    lsu_state_e next_state;

    // Stage 1 access
    logic              p1_valid;
    logic              p1_uncached;
    req_size_e         p1_size;
    logic [ADDR_W-1:0] p1_addr;
    logic [DATA_W-1:0] p1_wdata;
    logic [NBYTES-1:0] p1_wstrb;

    logic accept;
    logic new_cached;

    // A hit in the lookup cycle frees stage 1 for the next access
    assign cpu_ready  = (state == IDLE) && (!p1_valid || dc_ready);
    assign accept     = cpu_valid && cpu_ready && !cpu_flush;
    assign new_cached = accept && !cpu_uncached;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                // Miss or store seen in the lookup cycle
                if (p1_valid && !p1_uncached && !dc_ready) begin
                    next_state = REFILL_WAIT;
                end else if (accept && cpu_uncached) begin
                    next_state = UNC_SEND;
                end
            end
            REFILL_WAIT: begin
                if (dc_ready) begin
                    next_state = IDLE;
                end
            end
            UNC_SEND: begin
                if (cpu_flush) begin
                    next_state = IDLE;
                end else if (unc_ready) begin
                    next_state = UNC_WAIT;
                end
            end
            UNC_WAIT: begin
                if (unc_data_ok) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || cpu_flush) begin
            p1_valid <= 1'b0;
        end else if (accept) begin
            p1_valid <= 1'b1;
        end else if (dc_ready || unc_data_ok) begin
            p1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            p1_uncached <= cpu_uncached;
            p1_size     <= cpu_size;
            p1_addr     <= cpu_addr;
            p1_wdata    <= cpu_wdata;
            p1_wstrb    <= cpu_wstrb;
        end
    end

    // Index read for the next access
    assign dc_pre_valid = (state == IDLE) && cpu_pre_valid && !cpu_flush;
    assign dc_vaddr     = cpu_vaddr;

    always_comb begin
        if (new_cached) begin
            dc_valid = 1'b1;
            dc_addr  = cpu_addr;
            dc_wdata = cpu_wdata;
            dc_wstrb = cpu_wstrb;
        end else begin
            // Held request goes back to the cache until it answers
            dc_valid = p1_valid && !p1_uncached && !dc_ready
                       && (state == IDLE || state == REFILL_WAIT);
            dc_addr  = p1_addr;
            dc_wdata = p1_wdata;
            dc_wstrb = p1_wstrb;
        end
    end

    assign unc_valid = (state == UNC_SEND) && !cpu_flush;
    assign unc_size  = p1_size;
    assign unc_addr  = p1_addr;
    assign unc_wdata = p1_wdata;
    assign unc_wstrb = p1_wstrb;

    always_comb begin
        if (state == UNC_WAIT) begin
            cpu_rdata      = unc_rdata;
            cpu_data_valid = unc_data_ok && p1_valid;
        end else begin
            cpu_rdata      = dc_rdata;
            cpu_data_valid = dc_ready && p1_valid;
        end
    end

endmodule

//--- lsu_pkg.sv
package lsu_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int NBYTES = DATA_W / 8;

    // Direct mapped with 16 lines of one word
    localparam int IDX_W = 4;
    localparam int TAG_W = ADDR_W - IDX_W - 2;

    typedef enum logic [2:0] {
        SIZE_BYTE = 3'd0,
        SIZE_HALF = 3'd1,
        SIZE_WORD = 3'd2
    } req_size_e;

    typedef enum logic [1:0] {
        IDLE,
        REFILL_WAIT,
        UNC_SEND,
        UNC_WAIT
    } lsu_state_e;

    typedef enum logic [1:0] {
        DC_IDLE,
        DC_LOOKUP,
        DC_MEM
    } dc_state_e;

    typedef enum logic {
        UC_IDLE,
        UC_BUSY
    } unc_state_e;

endpackage

//--- mem_subsys.f
lsu_pkg.sv
lsu.sv
dcache.sv
uncache_channel.sv
mem_subsys.sv
tb_mem_model.sv
mem_subsys_tb.sv

//--- mem_subsys.sv
module mem_subsys (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       cpu_pre_valid,
    input  logic [lsu_pkg::ADDR_W-1:0] cpu_vaddr,
    input  logic                       cpu_valid,
    input  logic                       cpu_uncached,
    input  lsu_pkg::req_size_e         cpu_size,
    input  logic [lsu_pkg::ADDR_W-1:0] cpu_addr,
    input  logic [lsu_pkg::DATA_W-1:0] cpu_wdata,
    input  logic [lsu_pkg::NBYTES-1:0] cpu_wstrb,
    input  logic                       cpu_flush,
    output logic                       cpu_ready,
    output logic [lsu_pkg::DATA_W-1:0] cpu_rdata,
    output logic                       cpu_data_valid,

    output logic                       mem_req,
    output logic                       mem_we,
    output logic [lsu_pkg::ADDR_W-1:0] mem_addr,
    output logic [lsu_pkg::DATA_W-1:0] mem_wdata,
    output logic [lsu_pkg::NBYTES-1:0] mem_wstrb,
    input  logic                       mem_ack,
    input  logic [lsu_pkg::DATA_W-1:0] mem_rdata,

    output logic                       bus_req,
    output logic                       bus_we,
    output lsu_pkg::req_size_e         bus_size,
    output logic [lsu_pkg::ADDR_W-1:0] bus_addr,
    output logic [lsu_pkg::DATA_W-1:0] bus_wdata,
    output logic [lsu_pkg::NBYTES-1:0] bus_wstrb,
    input  logic                       bus_ack,
    input  logic [lsu_pkg::DATA_W-1:0] bus_rdata
);
    import lsu_pkg::*;

    // Unit to cache
    logic              dc_pre_valid;
    logic [ADDR_W-1:0] dc_vaddr;
    logic              dc_valid;
    logic [ADDR_W-1:0] dc_addr;
    logic [DATA_W-1:0] dc_wdata;
    logic [NBYTES-1:0] dc_wstrb;
    logic [DATA_W-1:0] dc_rdata;
    logic              dc_ready;

    // Unit to uncached channel
    logic              unc_valid;
    req_size_e         unc_size;
    logic [ADDR_W-1:0] unc_addr;
    logic [DATA_W-1:0] unc_wdata;
    logic [NBYTES-1:0] unc_wstrb;
    logic              unc_ready;
    logic [DATA_W-1:0] unc_rdata;
    logic              unc_data_ok;

    lsu i_lsu (.*);

    dcache i_dcache (.*);

    uncache_channel i_uncache_channel (.*);

endmodule

//--- mem_subsys_tb.sv
module mem_subsys_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_pkg::*;

    logic              clk;
    logic              rst;
    logic              cpu_pre_valid;
    logic [ADDR_W-1:0] cpu_vaddr;
    logic              cpu_valid;
    logic              cpu_uncached;
    req_size_e         cpu_size;
    logic [ADDR_W-1:0] cpu_addr;
    logic [DATA_W-1:0] cpu_wdata;
    logic [NBYTES-1:0] cpu_wstrb;
    logic              cpu_flush;
    logic              cpu_ready;
    logic [DATA_W-1:0] cpu_rdata;
    logic              cpu_data_valid;
    logic              mem_req;
    logic              mem_we;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic [NBYTES-1:0] mem_wstrb;
    logic              mem_ack;
    logic [DATA_W-1:0] mem_rdata;
    logic              bus_req;
    logic              bus_we;
    req_size_e         bus_size;
    logic [ADDR_W-1:0] bus_addr;
    logic [DATA_W-1:0] bus_wdata;
    logic [NBYTES-1:0] bus_wstrb;
    logic              bus_ack;
    logic [DATA_W-1:0] bus_rdata;
    req_size_e         last_bus_size;
    logic              last_bus_we;

    // Expected memory contents
    logic [DATA_W-1:0] ref_mem [int unsigned];
    int                error_count;

    mem_subsys i_dut (.*);

    tb_mem_model i_mem (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        if (ref_mem.exists(addr[ADDR_W-1:2])) begin
            return ref_mem[addr[ADDR_W-1:2]];
        end
        return ~{2'b00, addr[ADDR_W-1:2]};
    endfunction

    function automatic void store_expected(input logic [ADDR_W-1:0] addr,
                                           input logic [DATA_W-1:0] data,
                                           input logic [NBYTES-1:0] strb);
        logic [DATA_W-1:0] w;
        w = expected_word(addr);
        for (int b = 0; b < NBYTES; b++) begin
            if (strb[b]) begin
                w[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        ref_mem[addr[ADDR_W-1:2]] = w;
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED t=%0t %s got=%h expected=%h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("ERROR t=%0t %s", $time, what);
        error_count++;
    endtask

    // One access; cycles counts falling edges from cpu_valid to the data pulse
    task automatic do_access(input logic [ADDR_W-1:0] addr, input logic uncached,
                             input req_size_e size, input logic [DATA_W-1:0] wdata,
                             input logic [NBYTES-1:0] wstrb,
                             output logic [DATA_W-1:0] rdata, output int cycles);
        int wait_cnt;
        wait_cnt = 0;
        rdata    = '0;
        cycles   = 0;
        @(negedge clk);
        while (!cpu_ready && wait_cnt < 50) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!cpu_ready) begin
            report_problem("cpu_ready stayed low before an access");
            return;
        end
        cpu_pre_valid = 1'b1;
        cpu_vaddr     = addr;
        @(negedge clk);
        cpu_pre_valid = 1'b0;
        cpu_valid     = 1'b1;
        cpu_uncached  = uncached;
        cpu_size      = size;
        cpu_addr      = addr;
        cpu_wdata     = wdata;
        cpu_wstrb     = wstrb;
        while (cycles < 40) begin
            @(negedge clk);
            cycles++;
            if (cpu_data_valid) begin
                rdata     = cpu_rdata;
                cpu_valid = 1'b0;
                return;
            end
            cpu_valid = 1'b0;
        end
        report_problem("no cpu_data_valid within 40 cycles");
    endtask

    task automatic cached_load_miss_then_hit();
        logic [DATA_W-1:0] rd;
        int                cyc;
        do_access(32'h100, 1'b0, SIZE_WORD, '0, '0, rd, cyc);
        check_value("cpu_rdata", rd, expected_word(32'h100));
        do_access(32'h100, 1'b0, SIZE_WORD, '0, '0, rd, cyc);
        check_value("cpu_rdata", rd, expected_word(32'h100));
        check_value("hit_latency", cyc, 1);
    endtask

    task automatic cached_byte_store();
        logic [DATA_W-1:0] rd;
        int                cyc;
        do_access(32'h101, 1'b0, SIZE_BYTE, 32'h0000ab00, 4'b0010, rd, cyc);
        store_expected(32'h101, 32'h0000ab00, 4'b0010);
        do_access(32'h100, 1'b0, SIZE_WORD, '0, '0, rd, cyc);
        check_value("cpu_rdata", rd, expected_word(32'h100));
        check_value("mem_word", i_mem.read_word(32'h100), expected_word(32'h100));
    endtask

    task automatic uncached_load_bypass();
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] old_word;
        int                cyc;
        do_access(32'h204, 1'b1, SIZE_HALF, '0, '0, rd, cyc);
        check_value("cpu_rdata", rd, expected_word(32'h204));
        check_value("bus_size", last_bus_size, SIZE_HALF);
        // Fill the line, then change memory behind the cache
        do_access(32'h208, 1'b0, SIZE_WORD, '0, '0, rd, cyc);
        old_word = expected_word(32'h208);
        do_access(32'h208, 1'b1, SIZE_WORD, 32'h12345678, 4'b1111, rd, cyc);
        store_expected(32'h208, 32'h12345678, 4'b1111);
        do_access(32'h208, 1'b0, SIZE_WORD, '0, '0, rd, cyc);
        check_value("stale_rdata", rd, old_word);
        // Alias on index 2 evicts the stale line
        do_access(32'h248, 1'b0, SIZE_WORD, '0, '0, rd, cyc);
        check_value("cpu_rdata", rd, expected_word(32'h248));
        do_access(32'h208, 1'b0, SIZE_WORD, '0, '0, rd, cyc);
        check_value("cpu_rdata", rd, expected_word(32'h208));
        if (cyc <= 1) begin
            report_problem("load after eviction did not miss");
        end
    endtask

    task automatic uncached_store();
        logic [DATA_W-1:0] rd;
        int                cyc;
        int                extra;
        extra = 0;
        do_access(32'h300, 1'b1, SIZE_HALF, 32'hcafe0000, 4'b1100, rd, cyc);
        store_expected(32'h300, 32'hcafe0000, 4'b1100);
        repeat (4) begin
            @(negedge clk);
            if (cpu_data_valid) begin
                extra++;
            end
        end
        if (extra != 0) begin
            report_problem("uncached store pulsed cpu_data_valid more than once");
        end
        check_value("mem_word", i_mem.read_word(32'h300), expected_word(32'h300));
        check_value("bus_we", last_bus_we, 1'b1);
    endtask

    task automatic alias_eviction();
        logic [DATA_W-1:0] rd;
        int                cyc;
        do_access(32'h010, 1'b0, SIZE_WORD, '0, '0, rd, cyc);
        check_value("cpu_rdata", rd, expected_word(32'h010));
        do_access(32'h050, 1'b0, SIZE_WORD, '0, '0, rd, cyc);
        check_value("cpu_rdata", rd, expected_word(32'h050));
        do_access(32'h010, 1'b0, SIZE_WORD, '0, '0, rd, cyc);
        check_value("cpu_rdata", rd, expected_word(32'h010));
        if (cyc <= 1) begin
            report_problem("evicted line still hit");
        end
    endtask

    task automatic flush_squash();
        int pulses;
        pulses = 0;
        @(negedge clk);
        cpu_valid    = 1'b1;
        cpu_flush    = 1'b1;
        cpu_uncached = 1'b0;
        cpu_addr     = 32'h100;
        cpu_wstrb    = '0;
        repeat (10) begin
            @(negedge clk);
            cpu_valid = 1'b0;
            cpu_flush = 1'b0;
            if (cpu_data_valid) begin
                pulses++;
            end
            if (!cpu_ready) begin
                report_problem("cpu_ready dropped after a flushed access");
            end
        end
        if (pulses != 0) begin
            report_problem("flushed access produced a data pulse");
        end
    endtask

    initial begin
        void'($urandom(75276));
        error_count   = 0;
        rst           = 1'b1;
        cpu_pre_valid = 1'b0;
        cpu_vaddr     = '0;
        cpu_valid     = 1'b0;
        cpu_uncached  = 1'b0;
        cpu_size      = SIZE_WORD;
        cpu_addr      = '0;
        cpu_wdata     = '0;
        cpu_wstrb     = '0;
        cpu_flush     = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("cpu_data_valid", cpu_data_valid, 1'b0);
        check_value("mem_req", mem_req, 1'b0);
        check_value("bus_req", bus_req, 1'b0);
        check_value("cpu_ready", cpu_ready, 1'b1);

        cached_load_miss_then_hit();
        cached_byte_store();
        uncached_load_bypass();
        uncached_store();
        alias_eviction();
        flush_squash();

        $display("Checks done, errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f mem_subsys.f --top-module mem_subsys_tb -o sim_mem_subsys; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_mem_subsys > sim.log 2>&1; then
    cat sim.log
    echo "Simulation run failed"
    exit 1
fi

cat sim.log
if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "No pass line in sim.log"
    exit 1
fi
exit 0

//--- tb_mem_model.sv
module tb_mem_model (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       mem_req,
    input  logic                       mem_we,
    input  logic [lsu_pkg::ADDR_W-1:0] mem_addr,
    input  logic [lsu_pkg::DATA_W-1:0] mem_wdata,
    input  logic [lsu_pkg::NBYTES-1:0] mem_wstrb,
    output logic                       mem_ack,
    output logic [lsu_pkg::DATA_W-1:0] mem_rdata,

    input  logic                       bus_req,
    input  logic                       bus_we,
    input  lsu_pkg::req_size_e         bus_size,
    input  logic [lsu_pkg::ADDR_W-1:0] bus_addr,
    input  logic [lsu_pkg::DATA_W-1:0] bus_wdata,
    input  logic [lsu_pkg::NBYTES-1:0] bus_wstrb,
    output logic                       bus_ack,
    output logic [lsu_pkg::DATA_W-1:0] bus_rdata,
    output lsu_pkg::req_size_e         last_bus_size,
    output logic                       last_bus_we
);
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_pkg::*;

    // Sparse word store keyed by word address
    logic [DATA_W-1:0] words [int unsigned];
    logic              mem_busy;
    logic              bus_busy;
    int                mem_cnt;
    int                bus_cnt;

    function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] addr);
        int unsigned key;
        key = addr[ADDR_W-1:2];
        if (words.exists(key)) begin
            return words[key];
        end
        // Untouched words hold their inverted word address
        return ~{2'b00, addr[ADDR_W-1:2]};
    endfunction

    function automatic void write_word(input logic [ADDR_W-1:0] addr,
                                       input logic [DATA_W-1:0] data,
                                       input logic [NBYTES-1:0] strb);
        logic [DATA_W-1:0] w;
        w = read_word(addr);
        for (int b = 0; b < NBYTES; b++) begin
            if (strb[b]) begin
                w[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        words[addr[ADDR_W-1:2]] = w;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            mem_ack       <= 1'b0;
            bus_ack       <= 1'b0;
            mem_busy      <= 1'b0;
            bus_busy      <= 1'b0;
            mem_rdata     <= '0;
            bus_rdata     <= '0;
            last_bus_size <= SIZE_WORD;
            last_bus_we   <= 1'b0;
        end else begin
            if (mem_ack) begin
                mem_ack <= 1'b0;
            end else if (mem_busy) begin
                if (mem_cnt == 1) begin
                    mem_ack   <= 1'b1;
                    mem_busy  <= 1'b0;
                    mem_rdata <= read_word(mem_addr);
                    if (mem_we) begin
                        write_word(mem_addr, mem_wdata, mem_wstrb);
                    end
                end else begin
                    mem_cnt <= mem_cnt - 1;
                end
            end else if (mem_req) begin
                mem_busy <= 1'b1;
                mem_cnt  <= 1 + ($urandom % 4);
            end

            if (bus_ack) begin
                bus_ack <= 1'b0;
            end else if (bus_busy) begin
                if (bus_cnt == 1) begin
                    bus_ack       <= 1'b1;
                    bus_busy      <= 1'b0;
                    bus_rdata     <= read_word(bus_addr);
                    last_bus_size <= bus_size;
                    last_bus_we   <= bus_we;
                    if (bus_we) begin
                        write_word(bus_addr, bus_wdata, bus_wstrb);
                    end
                end else begin
                    bus_cnt <= bus_cnt - 1;
                end
            end else if (bus_req) begin
                bus_busy <= 1'b1;
                bus_cnt  <= 1 + ($urandom % 4);
            end
        end
    end

endmodule

//--- uncache_channel.sv
module uncache_channel (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       unc_valid,
    input  lsu_pkg::req_size_e         unc_size,
    input  logic [lsu_pkg::ADDR_W-1:0] unc_addr,
    input  logic [lsu_pkg::DATA_W-1:0] unc_wdata,
    input  logic [lsu_pkg::NBYTES-1:0] unc_wstrb,
    output logic                       unc_ready,
    output logic                       unc_data_ok,
    output logic [lsu_pkg::DATA_W-1:0] unc_rdata,

    output logic                       bus_req,
    output logic                       bus_we,
    output lsu_pkg::req_size_e         bus_size,
    output logic [lsu_pkg::ADDR_W-1:0] bus_addr,
    output logic [lsu_pkg::DATA_W-1:0] bus_wdata,
    output logic [lsu_pkg::NBYTES-1:0] bus_wstrb,
    input  logic                       bus_ack,
    input  logic [lsu_pkg::DATA_W-1:0] bus_rdata
);
    import lsu_pkg::*;

    unc_state_e state;
    logic       take;

    assign take      = (state == UC_IDLE) && unc_valid;
    assign unc_ready = state == UC_IDLE;
    assign bus_req   = state == UC_BUSY;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= UC_IDLE;
            unc_data_ok <= 1'b0;
        end else begin
            unc_data_ok <= 1'b0;
            case (state)
                UC_IDLE: begin
                    if (unc_valid) begin
                        state <= UC_BUSY;
                    end
                end
                UC_BUSY: begin
                    if (bus_ack) begin
                        state       <= UC_IDLE;
                        unc_data_ok <= 1'b1;
                    end
                end
                default: state <= UC_IDLE;
            endcase
        end
    end

    // Request held on the bus until acknowledged
    always_ff @(posedge clk) begin
        if (take) begin
            bus_we    <= |unc_wstrb;
            bus_size  <= unc_size;
            bus_addr  <= unc_addr;
            bus_wdata <= unc_wdata;
            bus_wstrb <= unc_wstrb;
        end
        if (bus_req && bus_ack) begin
            unc_rdata <= bus_rdata;
        end
    end

endmodule
